/* bench/serial_wb_bridge_tb.sv */
`timescale 1ns/1ps

module serial_wb_bridge_tb
	import serial_wb_pkg::*;
;

localparam int BYTES      = 2;
localparam int ADDR_BITS  = 10;
localparam int WORD_W     = BYTES*8;
localparam int WORDS      = 1 << ADDR_BITS;
localparam int ADDR_BYTES = addr_bytes(ADDR_BITS);

logic       clk;
logic       sresetn;
logic       in_tvalid;
logic       in_tready;
logic       in_tlast;
logic [7:0] in_tdata;
logic       out_tready;
logic       out_tvalid;
logic       out_tlast;
logic [7:0] out_tdata;

logic [WORD_W-1:0] model [int]; // Reference memory with one word per address
logic [8:0]        exp_q [$];   // Expected {tlast, byte} on the output
bit                read_busy;
bit                bp_on;       // Random out_tready
string             cur_test;
int                test_errs;
int                pass_cnt;
int                fail_cnt;
int                budget_bytes; // Bytes sent plus received so far
int                cycles;

serial_wb_bridge_top #(
	.BYTES     (BYTES),
	.ADDR_BITS (ADDR_BITS)
) serial_wb_bridge_top_i (
	.clk        (clk),
	.sresetn    (sresetn),
	.in_tvalid  (in_tvalid),
	.in_tready  (in_tready),
	.in_tlast   (in_tlast),
	.in_tdata   (in_tdata),
	.out_tready (out_tready),
	.out_tvalid (out_tvalid),
	.out_tlast  (out_tlast),
	.out_tdata  (out_tdata)
);

initial
begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

task automatic report_mismatch(input string what, input logic [15:0] want,
	input logic [15:0] got);
	$display("FAILED %s: %s expected 0x%h actual 0x%h", cur_test, what, want, got);
	test_errs++;
endtask

// Holds the byte until the DUT takes it
task automatic send_byte(input logic [7:0] b, input logic last);
	in_tvalid <= 1'b1;
	in_tdata  <= b;
	in_tlast  <= last;
	@(posedge clk);
	while (!in_tready)
		@(posedge clk);
endtask

// Op, big-endian address, count, then MSB-first words for writes
task automatic send_cmd(input bit wr, input bit inc, input int addr, input int cnt);
	logic [7:0]        op;
	logic [WORD_W-1:0] word;
	int                a;
	op               = '0;
	op[OP_WRITE_BIT] = wr;
	op[OP_INCR_BIT]  = inc;
	budget_bytes += 2 + ADDR_BYTES + cnt*BYTES;
	send_byte(op, 1'b0);
	for (int i = ADDR_BYTES-1; i >= 0; i--)
		send_byte(8'(addr >> (8*i)), 1'b0);
	send_byte(8'(cnt), !wr);
	for (int i = 0; i < cnt; i++)
	begin
		a = inc ? (addr + i) % WORDS : addr % WORDS; // Address holds when not incrementing
		if (wr)
		begin
			word     = WORD_W'($urandom);
			model[a] = word;
			for (int b = BYTES-1; b >= 0; b--)
				send_byte(word[8*b +: 8], (i == cnt-1) && (b == 0));
		end
		else
		begin
			word = model[a];
			for (int b = BYTES-1; b >= 0; b--)
				exp_q.push_back({b == 0, word[8*b +: 8]}); // tlast on each word's last byte
			read_busy = 1'b1;
		end
	end
endtask

task automatic start_test(input string name);
	cur_test  = name;
	test_errs = 0;
endtask

task automatic end_test();
	in_tvalid <= 1'b0;
	while (read_busy)
		@(posedge clk);
	do
		@(posedge clk);
	while (!in_tready);
	if (test_errs == 0)
	begin
		pass_cnt++;
		$display("PASSED %s, sequencer in %s", cur_test,
			serial_wb_bridge_top_i.master_i.state.name());
	end
	else
	begin
		fail_cnt++;
		$display("FAILED %s after %0d failing checks, sequencer in %s", cur_test, test_errs,
			serial_wb_bridge_top_i.master_i.state.name());
	end
endtask

always @(posedge clk)
	out_tready <= bp_on ? ($urandom % 3 != 0) : 1'b1;

// Output byte checker
always @(posedge clk)
begin
	logic [8:0] want;
	if (sresetn && out_tvalid && out_tready)
	begin
		assert (exp_q.size() != 0)
		else
		begin
			$display("Output byte 0x%h arrived in %s with no read in progress",
				out_tdata, cur_test);
			test_errs++;
		end
		if (exp_q.size() != 0)
		begin
			want = exp_q.pop_front();
			assert ({out_tlast, out_tdata} == want)
			else
				report_mismatch("output {tlast, byte}", 16'(want), 16'({out_tlast, out_tdata}));
			read_busy = (exp_q.size() != 0);
		end
	end
end

assert property (@(posedge clk) disable iff (!sresetn) read_busy |-> !in_tready)
else
begin
	$display("in_tready went high in %s while read data was still due", cur_test);
	test_errs++;
end

assert property (@(posedge clk) disable iff (!sresetn)
	out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
else
begin
	$display("Output byte changed under back-pressure in %s", cur_test);
	test_errs++;
end

// Limit grows with every command queued
initial
begin
	cycles = 0;
	while (cycles <= 20*budget_bytes + 200)
	begin
		@(posedge clk);
		cycles++;
	end
	$display("Run timed out after %0d cycles in %s", cycles, cur_test);
	$display("Test failed");
	$finish;
end

initial
begin
	int n;
	int a;
	int off;
	bit wr;
	bit inc;
	void'($urandom(29));
	sresetn    = 1'b0;
	in_tvalid  = 1'b0;
	in_tlast   = 1'b0;
	in_tdata   = '0;
	out_tready = 1'b1;
	repeat (3) @(posedge clk);
	sresetn <= 1'b1;

	start_test("reset_state");
	repeat (4)
	begin
		@(posedge clk);
		assert (!out_tvalid) else report_mismatch("out_tvalid", 16'd0, 16'(out_tvalid));
		assert (in_tready) else report_mismatch("in_tready", 16'd1, 16'(in_tready));
		assert (!serial_wb_bridge_top_i.wb.cyc && !serial_wb_bridge_top_i.wb.stb)
		else
			report_mismatch("cyc, stb", 16'd0, 16'({serial_wb_bridge_top_i.wb.cyc,
				serial_wb_bridge_top_i.wb.stb}));
		assert (serial_wb_bridge_top_i.master_i.state == GET_OP)
		else
			report_mismatch("state", 16'(GET_OP), 16'(serial_wb_bridge_top_i.master_i.state));
	end
	end_test();

	start_test("incr_burst");
	n = 1 + $urandom % 32;
	a = $urandom % (WORDS - n);
	send_cmd(1'b1, 1'b1, a, n);
	send_cmd(1'b0, 1'b1, a, n);
	end_test();

	start_test("fixed_addr");
	n = 4 + $urandom % 12;
	a = 32 + $urandom % 200;
	send_cmd(1'b1, 1'b1, a, n); // Prior values for the neighbours
	send_cmd(1'b1, 1'b0, a, 3 + $urandom % 5);
	send_cmd(1'b0, 1'b1, a, n);
	end_test();

	start_test("out_backpressure");
	send_cmd(1'b1, 1'b1, 'h040, 255);
	bp_on <= 1'b1;
	send_cmd(1'b0, 1'b1, 'h040, 255);
	end_test();
	bp_on <= 1'b0;

	start_test("two_byte_addr");
	a = 'h2a0 + $urandom % 64;
	send_cmd(1'b1, 1'b1, a - 2, 2);
	send_cmd(1'b1, 1'b1, a, 4);
	send_cmd(1'b0, 1'b1, a - 2, 6); // Spans both writes
	end_test();

	start_test("back_to_back");
	send_cmd(1'b1, 1'b1, 'h180, 64);
	repeat (12)
	begin
		wr  = $urandom % 2;
		inc = $urandom % 2;
		off = $urandom % 64;
		n   = inc ? 1 + $urandom % (64 - off) : 1 + $urandom % 16; // Stay inside the window
		send_cmd(wr, inc, 'h180 + off, n);
	end
	end_test();

	$display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
	if (fail_cnt == 0)
		$display("Test completed successfully");
	else
		$display("Test failed");
	$finish;
end

endmodule

/* include/axis_utility.svh */
`ifndef AXIS_UTILITY_SVH
`define AXIS_UTILITY_SVH

// Defines a function that reverses the byte order of an nbytes wide word
`define BYTE_SWAP_FUNCTION(name, nbytes) \
function automatic logic [(nbytes)*8-1:0] name(input logic [(nbytes)*8-1:0] din); \
	logic [(nbytes)*8-1:0] dout; \
	for (int i = 0; i < (nbytes); i++) \
		dout[i*8 +: 8] = din[((nbytes)-1-i)*8 +: 8]; \
	return dout; \
endfunction

`endif

/* logic/axis_fifo.sv */
`timescale 1ns/1ps

module axis_fifo #(
	parameter int BYTES      = 1,
	parameter int LOG2_DEPTH = 4
) (
	input logic    clk,
	input logic    sresetn,
	axis_if.sink   s_axis,
	axis_if.source m_axis
);

localparam int W     = BYTES*8;
localparam int DEPTH = 1 << LOG2_DEPTH;

logic [W:0]            mem [DEPTH]; // tlast kept above the data
logic [LOG2_DEPTH-1:0] wr_ptr;
logic [LOG2_DEPTH-1:0] rd_ptr;
logic [LOG2_DEPTH:0]   level; // Words held in mem
logic                  out_valid;
logic                  out_last;
logic [W-1:0]          out_data;
logic                  push;
logic                  out_free;
logic                  mem_empty;
logic                  bypass;
logic                  mem_wr;
logic                  mem_rd;

assign mem_empty = (level == '0);
assign push      = s_axis.tvalid && s_axis.tready;
assign out_free  = !out_valid || m_axis.tready;
assign bypass    = push && mem_empty && out_free; // Straight into the output register
assign mem_wr    = push && !bypass;
assign mem_rd    = out_free && !mem_empty;

assign s_axis.tready = (level != (LOG2_DEPTH+1)'(DEPTH));
assign m_axis.tvalid = out_valid;
assign m_axis.tlast  = out_last;
assign m_axis.tdata  = out_data;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		wr_ptr    <= '0;
		rd_ptr    <= '0;
		level     <= '0;
		out_valid <= 1'b0;
	end
	else
	begin
		if (mem_wr)
			wr_ptr <= wr_ptr + 1'b1;
		if (mem_rd)
			rd_ptr <= rd_ptr + 1'b1;
		if (mem_wr && !mem_rd)
			level <= level + 1'b1;
		else if (!mem_wr && mem_rd)
			level <= level - 1'b1;
		if (out_free)
			out_valid <= mem_rd || bypass;
	end
end

always_ff @(posedge clk)
begin
	if (mem_wr)
		mem[wr_ptr] <= {s_axis.tlast, s_axis.tdata};
	if (mem_rd)
		{out_last, out_data} <= mem[rd_ptr]; // Oldest word first
	else if (bypass)
		{out_last, out_data} <= {s_axis.tlast, s_axis.tdata};
end

endmodule

/* logic/axis_if.sv */
`timescale 1ns/1ps

interface axis_if #(
	parameter int BYTES = 1
);

	logic               tvalid;
	logic               tready;
	logic               tlast;
	logic [BYTES*8-1:0] tdata;

	modport source (
		output tvalid, tlast, tdata,
		input  tready
	);

	modport sink (
		input  tvalid, tlast, tdata,
		output tready
	);

endinterface

/* logic/axis_width_converter.sv */
`timescale 1ns/1ps

module axis_width_converter #(
	parameter int I_BYTES = 1,
	parameter int O_BYTES = 1
) (
	input logic    clk,
	input logic    sresetn,
	axis_if.sink   s_axis,
	axis_if.source m_axis
);

localparam int I_W = I_BYTES*8;
localparam int O_W = O_BYTES*8;

generate
	if (O_BYTES >= I_BYTES)
	begin : g_widen
		localparam int RATIO = O_BYTES / I_BYTES;
		localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

		logic [CNT_W-1:0] cnt; // Next piece slot
		logic             full;
		logic             last;
		logic [O_W-1:0]   word;
		logic             take_in;
		logic             take_out;

		assign take_in  = s_axis.tvalid && s_axis.tready;
		assign take_out = m_axis.tvalid && m_axis.tready;

		assign s_axis.tready = !full || m_axis.tready; // Room once the held word leaves
		assign m_axis.tvalid = full;
		assign m_axis.tlast  = last;
		assign m_axis.tdata  = word;

		always_ff @(posedge clk)
		begin
			if (!sresetn)
			begin
				cnt  <= '0;
				full <= 1'b0;
			end
			else
			begin
				if (take_out)
					full <= 1'b0;
				if (take_in)
				begin
					if (cnt == CNT_W'(RATIO-1))
					begin
						cnt  <= '0;
						full <= 1'b1;
					end
					else
						cnt <= cnt + 1'b1;
				end
			end
		end

		// Low piece first
		always_ff @(posedge clk)
		begin
			if (take_in)
			begin
				word[cnt*I_W +: I_W] <= s_axis.tdata;
				last                 <= s_axis.tlast; // Final piece wins
			end
		end
	end
	else
	begin : g_narrow
		localparam int RATIO = I_BYTES / O_BYTES;
		localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

		logic [CNT_W-1:0] cnt; // Pieces already sent
		logic             busy;
		logic             last;
		logic [I_W-1:0]   shreg;
		logic             final_piece;
		logic             take_in;
		logic             take_out;

		assign final_piece = (cnt == CNT_W'(RATIO-1));
		assign take_in     = s_axis.tvalid && s_axis.tready;
		assign take_out    = m_axis.tvalid && m_axis.tready;

		assign s_axis.tready = !busy || (m_axis.tready && final_piece);
		assign m_axis.tvalid = busy;
		assign m_axis.tlast  = last && final_piece;
		assign m_axis.tdata  = shreg[O_W-1:0];

		always_ff @(posedge clk)
		begin
			if (!sresetn)
			begin
				cnt  <= '0;
				busy <= 1'b0;
			end
			else
			begin
				if (take_out)
				begin
					cnt <= final_piece ? '0 : cnt + 1'b1;
					if (final_piece)
						busy <= 1'b0;
				end
				if (take_in)
				begin
					cnt  <= '0;
					busy <= 1'b1;
				end
			end
		end

		always_ff @(posedge clk)
		begin
			if (take_in)
			begin
				shreg <= s_axis.tdata;
				last  <= s_axis.tlast;
			end
			else if (take_out)
				shreg <= shreg >> O_W; // Next piece into the low lane
		end
	end
endgenerate

endmodule

/* logic/serial_wb_bridge_top.sv */
`timescale 1ns/1ps

module serial_wb_bridge_top #(
	parameter int BYTES     = 2,
	parameter int ADDR_BITS = 10
) (
	input  logic       clk,
	input  logic       sresetn,
	input  logic       in_tvalid,
	output logic       in_tready,
	input  logic       in_tlast,
	input  logic [7:0] in_tdata,
	input  logic       out_tready,
	output logic       out_tvalid,
	output logic       out_tlast,
	output logic [7:0] out_tdata
);

axis_if #(.BYTES(1)) in_axis ();
axis_if #(.BYTES(1)) out_axis ();
wb_if #(.BYTES(BYTES), .ADDR_BITS(ADDR_BITS)) wb ();

// Host side byte streams
assign in_axis.tvalid  = in_tvalid;
assign in_axis.tlast   = in_tlast;
assign in_axis.tdata   = in_tdata;
assign in_tready       = in_axis.tready;
assign out_axis.tready = out_tready;
assign out_tvalid      = out_axis.tvalid;
assign out_tlast       = out_axis.tlast;
assign out_tdata       = out_axis.tdata;

serial_wb_master #(
	.BYTES     (BYTES),
	.ADDR_BITS (ADDR_BITS)
) master_i (
	.clk     (clk),
	.sresetn (sresetn),
	.s_axis  (in_axis),
	.m_axis  (out_axis),
	.wb      (wb)
);

wb_ram #(
	.BYTES     (BYTES),
	.ADDR_BITS (ADDR_BITS)
) ram_i (
	.clk     (clk),
	.sresetn (sresetn),
	.wb      (wb)
);

endmodule

/* logic/serial_wb_master.sv */
`timescale 1ns/1ps
`include "axis_utility.svh"

module serial_wb_master
	import serial_wb_pkg::*;
#(
	parameter int BYTES     = 1,
	parameter int ADDR_BITS = 8
) (
	input logic    clk,
	input logic    sresetn,
	axis_if.sink   s_axis,
	axis_if.source m_axis,
	wb_if.master   wb
);

localparam int ADDR_BYTES = addr_bytes(ADDR_BITS);
localparam int CTR_W      = (ADDR_BYTES > 1) ? $clog2(ADDR_BYTES) : 1;

seq_state_t              state;
logic [7:0]              count; // Beats left after the current one
logic [8:0]              outstanding;
logic [CTR_W-1:0]        addr_ctr;
logic [ADDR_BYTES*8-1:0] addr; // Whole bytes with the top bits unused
logic                    incr;
logic                    we;
logic                    hdr_take;
logic                    beat_sent;
logic                    active_wr;
logic                    wr_done;
logic                    out_busy;

axis_if #(.BYTES(1))     widen_in ();
axis_if #(.BYTES(BYTES)) widen_out ();
axis_if #(.BYTES(BYTES)) fifo_in ();
axis_if #(.BYTES(BYTES)) fifo_out ();
axis_if #(.BYTES(BYTES)) narrow_in ();

`BYTE_SWAP_FUNCTION(byte_swap, BYTES)

assign hdr_take  = s_axis.tvalid && s_axis.tready;
assign beat_sent = wb.stb && !wb.stall;
assign active_wr = (state == BUS_ACTIVE) && we;
assign wr_done   = (count == 8'd0) && widen_out.tvalid; // Final word assembled
assign out_busy  = fifo_out.tvalid || m_axis.tvalid;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		state       <= GET_OP;
		outstanding <= '0;
	end
	else
	begin
		if (beat_sent && !wb.ack)
			outstanding <= outstanding + 9'd1;
		else if (!beat_sent && wb.ack)
			outstanding <= outstanding - 9'd1;

		// Stay on the last address so a burst never runs past it
		if (beat_sent && incr && (count != 8'd0))
			addr <= addr + 1'b1;

		case (state)
			GET_OP:
			begin
				if (hdr_take)
				begin
					we       <= s_axis.tdata[OP_WRITE_BIT];
					incr     <= s_axis.tdata[OP_INCR_BIT];
					addr_ctr <= CTR_W'(ADDR_BYTES-1);
					state    <= GET_ADDR;
				end
			end
			GET_ADDR:
			begin
				if (hdr_take)
				begin
					addr[addr_ctr*8 +: 8] <= s_axis.tdata; // Big-endian
					addr_ctr              <= addr_ctr - 1'b1;
					if (addr_ctr == '0)
						state <= GET_COUNT;
				end
			end
			GET_COUNT:
			begin
				if (hdr_take)
				begin
					count <= s_axis.tdata - 8'd1;
					state <= BUS_ACTIVE;
				end
			end
			BUS_ACTIVE:
			begin
				if (beat_sent)
				begin
					count <= count - 8'd1;
					if (count == 8'd0)
						state <= LAST_ACK;
				end
			end
			LAST_ACK:
			begin
				if ((outstanding == '0) && !out_busy)
					state <= GET_OP;
			end
			default:
				state <= GET_OP;
		endcase
	end
end

// Header bytes go to the sequencer and payload bytes to the widener
always_comb
begin
	case (state)
		GET_OP, GET_ADDR, GET_COUNT:
			s_axis.tready = 1'b1;
		BUS_ACTIVE:
			s_axis.tready = we && widen_in.tready && !wr_done;
		default:
			s_axis.tready = 1'b0;
	endcase
end

// Once the final word is assembled, further bytes belong to the next command
assign widen_in.tvalid = active_wr && s_axis.tvalid && !wr_done;
assign widen_in.tlast  = s_axis.tlast;
assign widen_in.tdata  = s_axis.tdata;

axis_width_converter #(
	.I_BYTES(1),
	.O_BYTES(BYTES)
) wr_widen (
	.clk     (clk),
	.sresetn (sresetn),
	.s_axis  (widen_in),
	.m_axis  (widen_out)
);

assign widen_out.tready = active_wr && !wb.stall;

assign wb.adr     = addr[ADDR_BITS-1:0];
assign wb.dat_m2s = byte_swap(widen_out.tdata);
assign wb.we      = we;
assign wb.stb     = (state == BUS_ACTIVE) && (!we || widen_out.tvalid);
assign wb.cyc     = (state == BUS_ACTIVE) || (state == LAST_ACK);

// Every read word closes with tlast
assign fifo_in.tvalid = wb.ack && !we;
assign fifo_in.tlast  = 1'b1;
assign fifo_in.tdata  = wb.dat_s2m;

axis_fifo #(
	.BYTES      (BYTES),
	.LOG2_DEPTH (FIFO_LOG2_DEPTH)
) rd_fifo (
	.clk     (clk),
	.sresetn (sresetn),
	.s_axis  (fifo_in),
	.m_axis  (fifo_out)
);

assign narrow_in.tvalid = fifo_out.tvalid;
assign narrow_in.tlast  = fifo_out.tlast;
assign narrow_in.tdata  = byte_swap(fifo_out.tdata); // MSB leaves first
assign fifo_out.tready  = narrow_in.tready;

axis_width_converter #(
	.I_BYTES(BYTES),
	.O_BYTES(1)
) rd_narrow (
	.clk     (clk),
	.sresetn (sresetn),
	.s_axis  (narrow_in),
	.m_axis  (m_axis)
);

endmodule

/* logic/serial_wb_pkg.sv */
package serial_wb_pkg;

	// Command sequencer states
	typedef enum logic [2:0]
	{
		GET_OP     = 3'd0,
		GET_ADDR   = 3'd1,
		GET_COUNT  = 3'd2,
		BUS_ACTIVE = 3'd3,
		LAST_ACK   = 3'd4
	} seq_state_t;

	// Bit positions in the op byte
	localparam int OP_WRITE_BIT = 0;
	localparam int OP_INCR_BIT  = 1;

	// Read FIFO holds the largest burst of 255 words
	localparam int FIFO_LOG2_DEPTH = 8;

	// Address bytes sent on the stream, rounded up to whole bytes
	function automatic int addr_bytes(input int bits);
		return (bits + 7) / 8;
	endfunction

endpackage

/* logic/wb_if.sv */
`timescale 1ns/1ps

// Pipelined Wishbone, one ack per issued beat
interface wb_if #(
	parameter int BYTES     = 1,
	parameter int ADDR_BITS = 8
);

	logic [ADDR_BITS-1:0] adr;
	logic [BYTES*8-1:0]   dat_m2s;
	logic [BYTES*8-1:0]   dat_s2m;
	logic                 we;
	logic                 stb;
	logic                 cyc;
	logic                 ack;
	logic                 stall;

	modport master (
		output adr, dat_m2s, we, stb, cyc,
		input  dat_s2m, ack, stall
	);

	modport slave (
		input  adr, dat_m2s, we, stb, cyc,
		output dat_s2m, ack, stall
	);

endinterface

/* logic/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
	parameter int BYTES     = 1,
	parameter int ADDR_BITS = 8
) (
	input logic clk,
	input logic sresetn,
	wb_if.slave wb
);

localparam int WORDS = 1 << ADDR_BITS;

logic [BYTES*8-1:0] mem [WORDS];
logic               issue;

assign issue    = wb.cyc && wb.stb && !wb.stall;
assign wb.stall = 1'b0; // Accepts a beat every cycle

// One ack per issued beat, one cycle later
always_ff @(posedge clk)
begin
	if (!sresetn)
		wb.ack <= 1'b0;
	else
		wb.ack <= issue;
end

always_ff @(posedge clk)
begin
	if (issue)
	begin
		if (wb.we)
			mem[wb.adr] <= wb.dat_m2s; // All lanes written
		else
			wb.dat_s2m <= mem[wb.adr];
	end
end

endmodule

/* serial_wb_bridge_top.f */
+incdir+include
logic/serial_wb_pkg.sv
logic/axis_if.sv
logic/wb_if.sv
logic/axis_width_converter.sv
logic/axis_fifo.sv
logic/serial_wb_master.sv
logic/wb_ram.sv
logic/serial_wb_bridge_top.sv
bench/serial_wb_bridge_tb.sv
